/* chip_pkg.sv */
`default_nettype none

package chip_pkg;

	// --------------------------------------------------
	// sizes and timing
	// --------------------------------------------------
	localparam int CLKS_PER_BIT = 8; // one fixed bit rate
	localparam int IMEM_DEPTH = 256;
	localparam int DMEM_DEPTH = 256;

	typedef logic [$clog2(CLKS_PER_BIT)-1:0] bit_cnt_t;
	typedef logic [15:0] word_t;
	typedef logic [7:0] addr_t;

	// --------------------------------------------------
	// instruction set
	// --------------------------------------------------
	// codes not listed here execute as a no-op
	typedef enum logic [3:0] {
		OP_LDI  = 4'h1,
		OP_ADD  = 4'h2,
		OP_SUB  = 4'h3,
		OP_AND  = 4'h4,
		OP_XOR  = 4'h5,
		OP_LD   = 4'h6,
		OP_ST   = 4'h7,
		OP_OUT  = 4'h8,
		OP_JNZ  = 4'h9,
		OP_HALT = 4'hf
	} opcode_t;

	typedef struct packed {
		opcode_t opcode;
		logic [11:0] operand; // addresses use the low 8 bits
	} instr_t;

	typedef struct packed {
		addr_t addr;
		word_t data;
	} mem_wr_t;

	typedef enum logic [2:0] {
		L_COUNT,
		L_HIGH,
		L_LOW,
		L_WRITE,
		L_SUM,
		L_DONE
	} loader_state_t;

	typedef enum logic [2:0] {
		C_FETCH,
		C_EXEC,
		C_LOAD,
		C_OUT,
		C_HALT
	} core_state_t;

endpackage

`default_nettype wire

/* bit_timer.sv */
`default_nettype none

module bit_timer import chip_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic run,
	output logic mid,
	output logic tick
);

	bit_cnt_t cnt;
	logic half_seen; // the half-bit pulse has been given in this run

	assign mid = run && !half_seen && cnt == bit_cnt_t'(CLKS_PER_BIT / 2 - 1);
	assign tick = run && half_seen && cnt == bit_cnt_t'(CLKS_PER_BIT - 1);

	// run low holds the counter cleared, so every rising run starts from zero
	always_ff @(posedge clk) begin
		if (!rst_n || !run) begin
			cnt <= '0;
			half_seen <= 1'b0;
		end else if (mid || tick) begin
			cnt <= '0;
			half_seen <= 1'b1;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* uart_rx.sv */
`default_nettype none

module uart_rx import chip_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic rx,
	output logic [7:0] rx_data,
	output logic rx_valid
);

	logic rx_meta;
	logic rx_sync;
	logic rx_prev;
	logic busy;
	logic [3:0] bit_idx; // data bits taken so far, 8 means the stop bit is next
	logic mid;
	logic tick;

	bit_timer timer (
		.clk(clk),
		.rst_n(rst_n),
		.run(busy),
		.mid(mid),
		.tick(tick)
	);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy <= 1'b0;
			bit_idx <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			if (!busy) begin
				if (rx_prev && !rx_sync) begin // falling edge, maybe a start bit
					busy <= 1'b1;
					bit_idx <= '0;
				end
			end else if (mid) begin
				busy <= !rx_sync; // line back high at the centre means a glitch
			end else if (tick) begin
				if (bit_idx == 4'd8) begin
					busy <= 1'b0;
					rx_valid <= rx_sync; // a low stop bit drops the frame
				end else begin
					bit_idx <= bit_idx + 1'b1;
				end
			end
		end
	end

	// LSB arrives first, so shift in from the top
	always_ff @(posedge clk) begin
		if (busy && tick && bit_idx != 4'd8) begin
			rx_data <= {rx_sync, rx_data[7:1]};
		end
	end

endmodule

`default_nettype wire

/* uart_tx.sv */
`default_nettype none

module uart_tx import chip_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic [7:0] tx_data,
	input logic tx_valid,
	output logic tx_busy,
	output logic tx
);

	logic [9:0] frame; // stop, data LSB first, start in bit 0
	logic [3:0] bit_idx;
	logic mid;
	logic tick;

	bit_timer timer (
		.clk(clk),
		.rst_n(rst_n),
		.run(tx_busy),
		.mid(mid),
		.tick(tick)
	);

	// the start bit goes out on mid, then each tick moves to the next bit
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			tx_busy <= 1'b0;
			bit_idx <= '0;
			tx <= 1'b1;
		end else if (!tx_busy) begin
			tx <= 1'b1;
			if (tx_valid) begin
				tx_busy <= 1'b1;
				bit_idx <= '0;
			end
		end else if (mid || tick) begin
			if (bit_idx == 4'd10) begin
				tx_busy <= 1'b0; // stop bit has had its full period
			end else begin
				tx <= frame[0];
				bit_idx <= bit_idx + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!tx_busy && tx_valid) begin
			frame <= {1'b1, tx_data, 1'b0};
		end else if (mid || tick) begin
			frame <= {1'b1, frame[9:1]};
		end
	end

endmodule

`default_nettype wire

/* memory.sv */
`default_nettype none

module memory import chip_pkg::*; #(
	parameter int DEPTH = IMEM_DEPTH
) (
	input logic clk,
	input mem_wr_t wr,
	input logic wr_valid,
	input addr_t rd_addr,
	output word_t rd_data
);

	word_t mem [DEPTH];

	// --------------------------------------------------
	// write port
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (wr_valid) begin
			mem[wr.addr] <= wr.data;
		end
	end

	// --------------------------------------------------
	// read port, data one clock after the address
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

/* program_loader.sv */
`default_nettype none

module program_loader import chip_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic [7:0] rx_data,
	input logic rx_valid,
	input logic tx_busy,
	output mem_wr_t imem_wr,
	output logic imem_wr_valid,
	output logic [7:0] tx_data,
	output logic tx_valid,
	output logic done
);

	typedef logic [$clog2(IMEM_DEPTH):0] count_t; // holds a count up to a full memory

	loader_state_t state;
	count_t remaining;
	addr_t wr_addr;
	logic [7:0] high_byte;
	logic [7:0] checksum;

	assign imem_wr_valid = state == L_WRITE;
	assign tx_valid = state == L_SUM && !tx_busy;
	assign tx_data = checksum;
	assign done = state == L_DONE;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= L_COUNT;
			remaining <= '0;
			wr_addr <= '0;
			checksum <= '0;
		end else begin
			case (state)
				L_COUNT: if (rx_valid) begin
					remaining <= count_t'(rx_data);
					checksum <= rx_data;
					wr_addr <= '0;
					state <= (rx_data == 8'd0) ? L_SUM : L_HIGH;
				end
				L_HIGH: if (rx_valid) begin
					checksum <= checksum ^ rx_data;
					state <= L_LOW;
				end
				L_LOW: if (rx_valid) begin
					checksum <= checksum ^ rx_data;
					state <= L_WRITE;
				end
				L_WRITE: begin
					wr_addr <= wr_addr + 1'b1;
					remaining <= remaining - 1'b1;
					state <= (remaining == count_t'(1)) ? L_SUM : L_HIGH;
				end
				L_SUM: if (!tx_busy) state <= L_DONE; // checksum goes out this cycle
				default: ; // done holds until the next reset
			endcase
		end
	end

	// instruction words are assembled high byte first
	always_ff @(posedge clk) begin
		if (rx_valid && state == L_HIGH) begin
			high_byte <= rx_data;
		end
		if (rx_valid && state == L_LOW) begin
			imem_wr <= '{addr: wr_addr, data: {high_byte, rx_data}};
		end
	end

endmodule

`default_nettype wire

/* core.sv */
`default_nettype none

module core import chip_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic run,
	input logic tx_busy,
	input word_t imem_rd_data,
	input word_t dmem_rd_data,
	output addr_t imem_rd_addr,
	output addr_t dmem_rd_addr,
	output mem_wr_t dmem_wr,
	output logic dmem_wr_valid,
	output logic [7:0] tx_data,
	output logic tx_valid,
	output logic halted
);

	core_state_t state;
	addr_t pc;
	word_t acc;
	instr_t instr;
	word_t operand;

	// the word at pc is on imem_rd_data by the time we reach C_EXEC
	assign instr = instr_t'(imem_rd_data);
	assign operand = word_t'(instr.operand); // zero extended
	assign imem_rd_addr = pc;

	// --------------------------------------------------
	// data memory and byte output
	// --------------------------------------------------
	assign dmem_rd_addr = instr.operand[7:0];
	assign dmem_wr = '{addr: instr.operand[7:0], data: acc};
	assign dmem_wr_valid = state == C_EXEC && instr.opcode == OP_ST;
	assign tx_data = acc[7:0];
	assign tx_valid = state == C_OUT && !tx_busy; // waits out a busy transmitter
	assign halted = state == C_HALT;

	// --------------------------------------------------
	// sequencer
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= C_FETCH;
			pc <= '0;
			acc <= '0;
		end else begin
			case (state)
				C_FETCH: if (run) state <= C_EXEC;
				C_EXEC: begin
					pc <= pc + 1'b1; // wraps past 255 back to 0
					state <= C_FETCH;
					case (instr.opcode)
						OP_LDI: acc <= operand;
						OP_ADD: acc <= acc + operand;
						OP_SUB: acc <= acc - operand;
						OP_AND: acc <= acc & operand;
						OP_XOR: acc <= acc ^ operand;
						OP_LD: state <= C_LOAD;
						OP_OUT: state <= C_OUT;
						OP_JNZ: begin
							if (acc != '0) begin
								pc <= instr.operand[7:0];
							end
						end
						OP_HALT: state <= C_HALT;
						default: ; // ST is handled by dmem_wr_valid
					endcase
				end
				C_LOAD: begin
					acc <= dmem_rd_data;
					state <= C_FETCH;
				end
				C_OUT: if (!tx_busy) state <= C_FETCH; // byte accepted this cycle
				default: ; // stays halted until reset
			endcase
		end
	end

endmodule

`default_nettype wire

/* chip.sv */
`default_nettype none

module chip import chip_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic uart_rx,
	output logic uart_tx,
	output logic halted
);

	logic [7:0] rx_data;
	logic rx_valid;
	logic [7:0] tx_data;
	logic tx_valid;
	logic tx_busy;
	logic [7:0] loader_tx_data;
	logic loader_tx_valid;
	logic [7:0] core_tx_data;
	logic core_tx_valid;
	logic done;

	mem_wr_t imem_wr;
	logic imem_wr_valid;
	addr_t imem_rd_addr;
	word_t imem_rd_data;
	mem_wr_t dmem_wr;
	logic dmem_wr_valid;
	addr_t dmem_rd_addr;
	word_t dmem_rd_data;

	uart_rx rx_inst (
		.clk(clk),
		.rst_n(rst_n),
		.rx(uart_rx),
		.rx_data(rx_data),
		.rx_valid(rx_valid)
	);

	uart_tx tx_inst (
		.clk(clk),
		.rst_n(rst_n),
		.tx_data(tx_data),
		.tx_valid(tx_valid),
		.tx_busy(tx_busy),
		.tx(uart_tx)
	);

	program_loader loader (
		.clk(clk),
		.rst_n(rst_n),
		.rx_data(rx_data),
		.rx_valid(rx_valid),
		.tx_busy(tx_busy),
		.imem_wr(imem_wr),
		.imem_wr_valid(imem_wr_valid),
		.tx_data(loader_tx_data),
		.tx_valid(loader_tx_valid),
		.done(done)
	);

	core cpu (
		.clk(clk),
		.rst_n(rst_n),
		.run(done),
		.tx_busy(tx_busy),
		.imem_rd_data(imem_rd_data),
		.dmem_rd_data(dmem_rd_data),
		.imem_rd_addr(imem_rd_addr),
		.dmem_rd_addr(dmem_rd_addr),
		.dmem_wr(dmem_wr),
		.dmem_wr_valid(dmem_wr_valid),
		.tx_data(core_tx_data),
		.tx_valid(core_tx_valid),
		.halted(halted)
	);

	memory #(.DEPTH(IMEM_DEPTH)) inst_mem (
		.clk(clk),
		.wr(imem_wr),
		.wr_valid(imem_wr_valid),
		.rd_addr(imem_rd_addr),
		.rd_data(imem_rd_data)
	);

	memory #(.DEPTH(DMEM_DEPTH)) main_mem (
		.clk(clk),
		.wr(dmem_wr),
		.wr_valid(dmem_wr_valid),
		.rd_addr(dmem_rd_addr),
		.rd_data(dmem_rd_data)
	);

	// the loader owns the transmitter until its checksum is out
	always_comb begin
		if (done) begin
			tx_valid = core_tx_valid;
			tx_data = core_tx_data;
		end else begin
			tx_valid = loader_tx_valid;
			tx_data = loader_tx_data;
		end
	end

endmodule

`default_nettype wire

/* chip_tb.sv */
`default_nettype none

module chip_tb import chip_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	typedef struct packed {
		word_t [15:0] prog;
		logic [4:0] len;
		logic bad_frame; // a frame with a low stop bit goes ahead of the count byte
		logic [7:0][7:0] outs; // core output bytes, the checksum is not in here
		logic [3:0] out_len;
	} test_t;

	logic clk = 1'b0;
	logic rst_n = 1'b0;
	logic rx_line = 1'b1;
	logic tx_line;
	logic halted;

	logic [7:0] got[$]; // bytes decoded from uart_tx
	test_t tests[$];
	test_t cur;
	int value_errors = 0;
	int other_errors = 0;
	int watchdog_clocks = 0;

	chip uut (
		.clk(clk),
		.rst_n(rst_n),
		.uart_rx(rx_line),
		.uart_tx(tx_line),
		.halted(halted)
	);

	always #10 clk = ~clk;

	// --------------------------------------------------
	// table of programs and expected output
	// --------------------------------------------------
	task automatic start_entry(input logic bad_frame);
		cur = '0;
		cur.bad_frame = bad_frame;
	endtask

	task automatic put_instr(input opcode_t op, input logic [11:0] operand);
		cur.prog[cur.len[3:0]] = {op, operand};
		cur.len = cur.len + 5'd1;
	endtask

	task automatic expect_out(input logic [7:0] value);
		cur.outs[cur.out_len[2:0]] = value;
		cur.out_len = cur.out_len + 4'd1;
	endtask

	task automatic build_table();
		start_entry(1'b0); // alu steps, SUB wraps below zero
		put_instr(OP_LDI, 12'h012);
		put_instr(OP_OUT, 12'h000);
		put_instr(OP_ADD, 12'h0f0);
		put_instr(OP_OUT, 12'h000);
		put_instr(OP_SUB, 12'h105);
		put_instr(OP_OUT, 12'h000);
		put_instr(OP_AND, 12'h0f0);
		put_instr(OP_OUT, 12'h000);
		put_instr(OP_XOR, 12'h0ff);
		put_instr(OP_OUT, 12'h000);
		put_instr(OP_HALT, 12'h000);
		expect_out(8'h12);
		expect_out(8'h02);
		expect_out(8'hfd);
		expect_out(8'hf0);
		expect_out(8'h0f);
		tests.push_back(cur);
		start_entry(1'b0); // data memory round trip
		put_instr(OP_LDI, 12'h13c);
		put_instr(OP_ST, 12'h010);
		put_instr(OP_LDI, 12'h05a);
		put_instr(OP_ST, 12'h020);
		put_instr(OP_LDI, 12'h000);
		put_instr(OP_LD, 12'h010);
		put_instr(OP_OUT, 12'h000);
		put_instr(OP_LD, 12'h020);
		put_instr(OP_OUT, 12'h000);
		put_instr(OP_HALT, 12'h000);
		expect_out(8'h3c);
		expect_out(8'h5a);
		tests.push_back(cur);
		start_entry(1'b0); // countdown loop, OUT stalls on a busy transmitter
		put_instr(OP_LDI, 12'h005);
		put_instr(OP_OUT, 12'h000);
		put_instr(OP_SUB, 12'h001);
		put_instr(OP_JNZ, 12'h001);
		put_instr(OP_HALT, 12'h000);
		for (int v = 5; v > 0; v--) begin
			expect_out(8'(v));
		end
		tests.push_back(cur);
		start_entry(1'b0); // nothing after HALT may come out
		put_instr(OP_LDI, 12'h077);
		put_instr(OP_OUT, 12'h000);
		put_instr(OP_HALT, 12'h000);
		put_instr(OP_LDI, 12'h011);
		put_instr(OP_OUT, 12'h000);
		put_instr(OP_HALT, 12'h000);
		expect_out(8'h77);
		tests.push_back(cur);
		start_entry(1'b1);
		put_instr(OP_LDI, 12'h0c3);
		put_instr(OP_XOR, 12'h081);
		put_instr(OP_OUT, 12'h000);
		put_instr(OP_HALT, 12'h000);
		expect_out(8'h42);
		tests.push_back(cur);
	endtask

	function automatic int watchdog_limit();
		int total;
		total = 0;
		foreach (tests[i]) begin
			total += int'(tests[i].bad_frame) + 1 + 2 * int'(tests[i].len);
			total += 1 + int'(tests[i].out_len);
		end
		return total * 12 * 2 * CLKS_PER_BIT + 2000;
	endfunction

	// --------------------------------------------------
	// checks and serial driver
	// --------------------------------------------------
	task automatic check_byte(input string name, input logic [7:0] expected,
			input logic [7:0] actual);
		if (actual !== expected) begin
			$display("** Error %s: expected 0x%h, got 0x%h", name, expected, actual);
			value_errors++;
		end
	endtask

	task automatic check_halt(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("** Error %s: expected 0x%h, got 0x%h", name, expected, actual);
			value_errors++;
		end
	endtask

	task automatic apply_reset();
		@(posedge clk);
		rst_n <= 1'b0;
		rx_line <= 1'b1;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
	endtask

	// start bit, 8 data bits LSB first, then the given stop bit
	task automatic send_frame(input logic [7:0] data, input logic stop_bit);
		logic [9:0] bits;
		bits = {stop_bit, data, 1'b0};
		for (int i = 0; i < 10; i++) begin
			rx_line <= bits[i];
			repeat (CLKS_PER_BIT) @(posedge clk);
		end
	endtask

	task automatic idle_bits(input int n);
		rx_line <= 1'b1;
		repeat (n * CLKS_PER_BIT) @(posedge clk);
	endtask

	task automatic run_test(input test_t t, input int idx);
		logic [7:0] sum;
		word_t w;
		int n;
		apply_reset();
		got.delete();
		@(negedge clk);
		check_halt("halted after reset", 1'b0, halted);
		@(posedge clk);
		if (t.bad_frame) begin
			send_frame(8'ha5, 1'b0);
			idle_bits(2);
		end
		sum = {3'b000, t.len};
		send_frame(sum, 1'b1);
		for (int i = 0; i < int'(t.len); i++) begin
			w = t.prog[4'(i)];
			idle_bits(int'($urandom_range(3, 0)));
			send_frame(w[15:8], 1'b1); // high byte first
			idle_bits(int'($urandom_range(3, 0)));
			send_frame(w[7:0], 1'b1);
			sum = sum ^ w[15:8] ^ w[7:0];
		end
		n = int'(t.out_len) + 1;
		while (got.size() < n) begin
			@(posedge clk);
		end
		idle_bits(24); // room for a stray frame to show up
		@(negedge clk);
		if (got.size() != n) begin
			$display("test %0d: expected %0d bytes on uart_tx but saw %0d", idx, n, got.size());
			other_errors++;
		end
		check_byte($sformatf("uart_tx checksum, test %0d", idx), sum, got[0]);
		for (int k = 1; k < n; k++) begin
			check_byte($sformatf("uart_tx byte %0d, test %0d", k, idx), t.outs[3'(k - 1)], got[k]);
		end
		check_halt($sformatf("halted, test %0d", idx), 1'b1, halted);
	endtask

	// decodes uart_tx at bit centres
	initial begin : tx_monitor
		logic [7:0] shift;
		logic prev;
		prev = 1'b1;
		forever begin
			@(negedge clk);
			if (prev === 1'b1 && tx_line === 1'b0) begin
				repeat (CLKS_PER_BIT / 2) @(negedge clk);
				for (int i = 0; i < 8; i++) begin
					repeat (CLKS_PER_BIT) @(negedge clk);
					shift = {tx_line, shift[7:1]};
				end
				repeat (CLKS_PER_BIT) @(negedge clk);
				if (tx_line !== 1'b1) begin
					$display("uart_tx frame ended with a low stop bit, byte dropped");
					other_errors++;
				end else begin
					got.push_back(shift);
				end
			end
			prev = tx_line;
		end
	end

	initial begin : watchdog
		wait (watchdog_clocks > 0);
		repeat (watchdog_clocks) @(posedge clk);
		$display("watchdog: run still going after %0d clocks", watchdog_clocks);
		$display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin : main
		void'($urandom(51283));
		build_table();
		watchdog_clocks = watchdog_limit();
		foreach (tests[i]) begin
			run_test(tests[i], i);
		end
		$display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* chip.f */
chip_pkg.sv
bit_timer.sv
uart_rx.sv
uart_tx.sv
memory.sv
program_loader.sv
core.sv
chip.sv
chip_tb.sv

/* run.sh */
#!/usr/bin/env bash
# compile and run the chip testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log
build_dir=obj_dir

verilator --binary --timing --timescale 1ns/1ps \
	--top-module chip_tb -f chip.f --Mdir "$build_dir" -o chip_sim
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

"./$build_dir/chip_sim" > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q "FAIL: see errors above" "$log"; then
	exit 1
fi
exit 0
